//--- verilog/retire_stats_config.svh
`ifndef RETIRE_STATS_CONFIG_SVH
`define RETIRE_STATS_CONFIG_SVH

//////////////////////////////
// Retire port bank
//////////////////////////////
`define RETIRE_PORTS 2

// Width of a per-cycle sum over all retire ports
`define SUM_W ($clog2(`RETIRE_PORTS + 1))

// Collection window markers, both encoded as addi x0 forms
`define START_MARKER 32'h00C00013
`define END_MARKER 32'h00D00013

// Statistic counters wrap at this width
`define COUNTER_W 32

//////////////////////////////
// Register map byte offsets
//////////////////////////////
`define REG_STATUS 8'h00
`define REG_CONTROL 8'h04
`define REG_RETIRED 8'h08
`define REG_CYCLES 8'h0C
// One word per mix category from here on
`define REG_MIX_BASE 8'h10
// Console data byte
`define REG_UART 8'h40

`endif

//--- verilog/rv_decode_pkg.sv
package rv_decode_pkg;

    //////////////////////////////
    // Opcode field, instr[6:2]
    //////////////////////////////
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        FENCE     = 5'b00011,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        AMO       = 5'b01011,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_t;

    //////////////////////////////
    // Instruction mix categories
    //////////////////////////////
    typedef enum int {
        MIX_ALU    = 0,
        MIX_BRANCH = 1,
        MIX_MUL    = 2,
        MIX_DIV    = 3,
        MIX_LOAD   = 4,
        MIX_STORE  = 5,
        MIX_MISC   = 6,
        // Number of categories, not a category itself
        MIX_COUNT  = 7
    } mix_e;

    // One flag per category for a single instruction
    typedef logic [MIX_COUNT-1:0] mix_vec_t;

endpackage

//--- verilog/stats_bus_pkg.sv
package stats_bus_pkg;

    // AXI4-Lite response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // Bit positions inside the status register
    typedef enum int {
        STATUS_ACTIVE = 0,
        STATUS_DONE   = 1
    } status_bits_e;

    // Decoded register selection
    typedef enum logic [2:0] {
        SEL_STATUS,
        SEL_CONTROL,
        SEL_RETIRED,
        SEL_CYCLES,
        SEL_MIX,
        SEL_UART,
        SEL_NONE
    } reg_sel_e;

endpackage

//--- verilog/retire_classifier.sv
`timescale 1ns/1ps
`include "retire_stats_config.svh"

module retire_classifier (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`RETIRE_PORTS-1:0] retire_valid,
    input  logic [31:0]              retire_instr [`RETIRE_PORTS],
    output logic [`SUM_W-1:0]        mix_sum [rv_decode_pkg::MIX_COUNT],
    output logic [`SUM_W-1:0]        retired_sum,
    output logic                     start_seen,
    output logic                     end_seen
);

    localparam int SUM_W = `SUM_W;

    rv_decode_pkg::mix_vec_t  port_mix [`RETIRE_PORTS];
    logic [`RETIRE_PORTS-1:0] port_start;
    logic [`RETIRE_PORTS-1:0] port_end;
    logic [`RETIRE_PORTS-1:0] port_counted;
    logic [SUM_W-1:0]         mix_next [rv_decode_pkg::MIX_COUNT];
    logic [SUM_W-1:0]         retired_next;

    // Mix flags for one word, markers are filtered out elsewhere
    function automatic rv_decode_pkg::mix_vec_t classify(input logic [31:0] instr);
        rv_decode_pkg::mix_vec_t mix;
        mix = '0;
        case (instr[6:2])
            // M extension shares the register opcode, split on bits 25 and 14
            rv_decode_pkg::ARITH: begin
                if (!instr[25])
                    mix[rv_decode_pkg::MIX_ALU] = 1'b1;
                else if (instr[14])
                    mix[rv_decode_pkg::MIX_DIV] = 1'b1;
                else
                    mix[rv_decode_pkg::MIX_MUL] = 1'b1;
            end
            rv_decode_pkg::ARITH_IMM, rv_decode_pkg::AUIPC, rv_decode_pkg::LUI:
                mix[rv_decode_pkg::MIX_ALU] = 1'b1;
            rv_decode_pkg::BRANCH, rv_decode_pkg::JAL, rv_decode_pkg::JALR:
                mix[rv_decode_pkg::MIX_BRANCH] = 1'b1;
            rv_decode_pkg::LOAD:
                mix[rv_decode_pkg::MIX_LOAD] = 1'b1;
            rv_decode_pkg::STORE:
                mix[rv_decode_pkg::MIX_STORE] = 1'b1;
            // Atomics both read and write memory
            rv_decode_pkg::AMO: begin
                mix[rv_decode_pkg::MIX_LOAD]  = 1'b1;
                mix[rv_decode_pkg::MIX_STORE] = 1'b1;
            end
            rv_decode_pkg::SYSTEM, rv_decode_pkg::FENCE:
                mix[rv_decode_pkg::MIX_MISC] = 1'b1;
            default: ;
        endcase
        return mix;
    endfunction

    //////////////////////////////
    // Per-port decode
    //////////////////////////////
    always_comb begin
        for (int p = 0; p < `RETIRE_PORTS; p++) begin
            port_start[p]   = retire_valid[p] && (retire_instr[p] == `START_MARKER);
            port_end[p]     = retire_valid[p] && (retire_instr[p] == `END_MARKER);
            port_counted[p] = retire_valid[p] && !port_start[p] && !port_end[p];
            port_mix[p]     = classify(retire_instr[p]);
        end
    end

    // Sum across ports
    always_comb begin
        mix_next     = '{default: '0};
        retired_next = '0;
        for (int p = 0; p < `RETIRE_PORTS; p++) begin
            if (port_counted[p]) begin
                retired_next = retired_next + 1'b1;
                for (int c = 0; c < rv_decode_pkg::MIX_COUNT; c++)
                    mix_next[c] = mix_next[c] + SUM_W'(port_mix[p][c]);
            end
        end
    end

    //////////////////////////////
    // Output stage
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mix_sum     <= '{default: '0};
            retired_sum <= '0;
            start_seen  <= 1'b0;
            end_seen    <= 1'b0;
        end else begin
            mix_sum     <= mix_next;
            retired_sum <= retired_next;
            start_seen  <= |port_start;
            end_seen    <= |port_end;
        end
    end

endmodule

//--- verilog/collection_counters.sv
`timescale 1ns/1ps
`include "retire_stats_config.svh"

module collection_counters (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`SUM_W-1:0]     mix_sum [rv_decode_pkg::MIX_COUNT],
    input  logic [`SUM_W-1:0]     retired_sum,
    input  logic                  start_seen,
    input  logic                  end_seen,
    input  logic                  clear_stats,
    output logic [`COUNTER_W-1:0] mix_count [rv_decode_pkg::MIX_COUNT],
    output logic [`COUNTER_W-1:0] retired_count,
    output logic [`COUNTER_W-1:0] cycle_count,
    output logic                  collect_active,
    output logic                  collect_done
);

    localparam int COUNTER_W = `COUNTER_W;

    logic open_window;
    logic close_window;

    // Start only matters while idle, end only while active
    assign open_window  = !collect_active && start_seen;
    assign close_window = collect_active && end_seen;

    //////////////////////////////
    // Window state
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            collect_active <= 1'b0;
        end else if (open_window) begin
            collect_active <= 1'b1;
        end else if (close_window) begin
            collect_active <= 1'b0;
        end
    end

    // Done marks a finished window until cleared or a new one opens
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            collect_done <= 1'b0;
        end else if (clear_stats) begin
            collect_done <= 1'b0;
        end else if (close_window) begin
            collect_done <= 1'b1;
        end else if (open_window) begin
            collect_done <= 1'b0;
        end
    end

    //////////////////////////////
    // Statistic counters
    //////////////////////////////

    // The end cycle still counts, the start cycle does not
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retired_count <= '0;
            cycle_count   <= '0;
        end else if (clear_stats) begin
            retired_count <= '0;
            cycle_count   <= '0;
        end else if (collect_active) begin
            retired_count <= retired_count + COUNTER_W'(retired_sum);
            cycle_count   <= cycle_count + 1'b1;
        end
    end

    // One counter per mix category
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mix_count <= '{default: '0};
        end else if (clear_stats) begin
            mix_count <= '{default: '0};
        end else if (collect_active) begin
            for (int c = 0; c < rv_decode_pkg::MIX_COUNT; c++)
                mix_count[c] <= mix_count[c] + COUNTER_W'(mix_sum[c]);
        end
    end

endmodule

//--- verilog/stats_axil_slave.sv
`timescale 1ns/1ps
`include "retire_stats_config.svh"

module stats_axil_slave (
    input  logic                     clk,
    input  logic                     arst_n,
    // Write address and data
    input  logic [7:0]               awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    // Write response
    output stats_bus_pkg::axil_resp_t bresp,
    output logic                     bvalid,
    input  logic                     bready,
    // Read address and data
    input  logic [7:0]               araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output stats_bus_pkg::axil_resp_t rresp,
    output logic                     rvalid,
    input  logic                     rready,
    // Statistics
    input  logic [`COUNTER_W-1:0]    mix_count [rv_decode_pkg::MIX_COUNT],
    input  logic [`COUNTER_W-1:0]    retired_count,
    input  logic [`COUNTER_W-1:0]    cycle_count,
    input  logic                     collect_active,
    input  logic                     collect_done,
    output logic                     clear_stats,
    output logic                     uart_valid,
    output logic [7:0]               uart_byte
);

    localparam int MIX_IDX_W = $clog2(rv_decode_pkg::MIX_COUNT);

    logic                    wr_ready_q;
    logic                    wr_fire;
    logic                    rd_fire;
    stats_bus_pkg::reg_sel_e wr_sel;
    stats_bus_pkg::reg_sel_e rd_sel;
    logic [7:0]              mix_offset;
    logic [MIX_IDX_W-1:0]    mix_idx;
    logic [31:0]             rd_data_next;

    // Offset to register selection, unaligned or out of range is unmapped
    function automatic stats_bus_pkg::reg_sel_e decode(input logic [7:0] addr);
        case (addr)
            `REG_STATUS:  return stats_bus_pkg::SEL_STATUS;
            `REG_CONTROL: return stats_bus_pkg::SEL_CONTROL;
            `REG_RETIRED: return stats_bus_pkg::SEL_RETIRED;
            `REG_CYCLES:  return stats_bus_pkg::SEL_CYCLES;
            `REG_UART:    return stats_bus_pkg::SEL_UART;
            default: begin
                if (addr >= `REG_MIX_BASE && addr[1:0] == 2'b00 &&
                    int'(addr) < int'(`REG_MIX_BASE) + 4 * rv_decode_pkg::MIX_COUNT)
                    return stats_bus_pkg::SEL_MIX;
                return stats_bus_pkg::SEL_NONE;
            end
        endcase
    endfunction

    assign wr_sel = decode(awaddr);
    assign rd_sel = decode(araddr);

    //////////////////////////////
    // Write channel
    //////////////////////////////
    assign awready = wr_ready_q;
    assign wready  = wr_ready_q;
    assign wr_fire = wr_ready_q && awvalid && wvalid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ready_q <= 1'b0;
            bvalid     <= 1'b0;
        end else begin
            // Single cycle ready, held off while a response waits
            wr_ready_q <= awvalid && wvalid && !bvalid && !wr_ready_q;
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp     <= (wr_sel == stats_bus_pkg::SEL_NONE) ?
                         stats_bus_pkg::RESP_SLVERR : stats_bus_pkg::RESP_OKAY;
            uart_byte <= wdata[7:0];
        end
    end

    // Side effects of accepted writes, one cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clear_stats <= 1'b0;
            uart_valid  <= 1'b0;
        end else begin
            clear_stats <= wr_fire && wr_sel == stats_bus_pkg::SEL_CONTROL &&
                           wstrb[0] && wdata[0];
            uart_valid  <= wr_fire && wr_sel == stats_bus_pkg::SEL_UART && wstrb[0];
        end
    end

    //////////////////////////////
    // Read channel
    //////////////////////////////
    assign rd_fire    = arready && arvalid;
    assign mix_offset = araddr - `REG_MIX_BASE;
    assign mix_idx    = mix_offset[2 +: MIX_IDX_W];

    always_comb begin
        rd_data_next = '0;
        case (rd_sel)
            stats_bus_pkg::SEL_STATUS: begin
                rd_data_next[stats_bus_pkg::STATUS_ACTIVE] = collect_active;
                rd_data_next[stats_bus_pkg::STATUS_DONE]   = collect_done;
            end
            stats_bus_pkg::SEL_RETIRED: rd_data_next = 32'(retired_count);
            stats_bus_pkg::SEL_CYCLES:  rd_data_next = 32'(cycle_count);
            stats_bus_pkg::SEL_MIX:     rd_data_next = 32'(mix_count[mix_idx]);
            // Control, UART and unmapped read as zero
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_data_next;
            rresp <= (rd_sel == stats_bus_pkg::SEL_NONE) ?
                     stats_bus_pkg::RESP_SLVERR : stats_bus_pkg::RESP_OKAY;
        end
    end

endmodule

//--- verilog/retire_stats.sv
`timescale 1ns/1ps
`include "retire_stats_config.svh"

module retire_stats (
    input  logic                      clk,
    input  logic                      arst_n,
    // Retire ports
    input  logic [`RETIRE_PORTS-1:0]  retire_valid,
    input  logic [31:0]               retire_instr [`RETIRE_PORTS],
    // AXI4-Lite slave
    input  logic [7:0]                awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output stats_bus_pkg::axil_resp_t bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [7:0]                araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output stats_bus_pkg::axil_resp_t rresp,
    output logic                      rvalid,
    input  logic                      rready,
    // Console and window state
    output logic                      uart_valid,
    output logic [7:0]                uart_byte,
    output logic                      collect_active
);

    logic [`SUM_W-1:0]     mix_sum [rv_decode_pkg::MIX_COUNT];
    logic [`SUM_W-1:0]     retired_sum;
    logic                  start_seen;
    logic                  end_seen;
    logic [`COUNTER_W-1:0] mix_count [rv_decode_pkg::MIX_COUNT];
    logic [`COUNTER_W-1:0] retired_count;
    logic [`COUNTER_W-1:0] cycle_count;
    logic                  collect_done;
    logic                  clear_stats;

    retire_classifier classifier (.*);

    collection_counters counters (.*);

    stats_axil_slave slave (.*);

endmodule

//--- verif/retire_stats_tb_util.svh
`ifndef RETIRE_STATS_TB_UTIL_SVH
`define RETIRE_STATS_TB_UTIL_SVH

//////////////////////////////
// Reference instruction mix
//////////////////////////////
function automatic rv_decode_pkg::mix_vec_t ref_classify(input logic [31:0] instr);
    rv_decode_pkg::mix_vec_t mix;
    logic [4:0]              op;
    mix = '0;
    op  = instr[6:2];
    // Multiply and divide only exist under the register opcode
    if (op == 5'b01100 && instr[25]) begin
        if (instr[14])
            mix[rv_decode_pkg::MIX_DIV] = 1'b1;
        else
            mix[rv_decode_pkg::MIX_MUL] = 1'b1;
    end else if (op inside {5'b01100, 5'b00100, 5'b00101, 5'b01101}) begin
        mix[rv_decode_pkg::MIX_ALU] = 1'b1;
    end else if (op inside {5'b11000, 5'b11001, 5'b11011}) begin
        mix[rv_decode_pkg::MIX_BRANCH] = 1'b1;
    end else if (op inside {5'b11100, 5'b00011}) begin
        mix[rv_decode_pkg::MIX_MISC] = 1'b1;
    end
    // AMO lands in both memory categories
    if (op == 5'b00000 || op == 5'b01011)
        mix[rv_decode_pkg::MIX_LOAD] = 1'b1;
    if (op == 5'b01000 || op == 5'b01011)
        mix[rv_decode_pkg::MIX_STORE] = 1'b1;
    return mix;
endfunction

// Random word from an opcode class or an unknown opcode
function automatic logic [31:0] rand_instr();
    logic [31:0] word;
    logic [4:0]  op;
    case ($urandom_range(12))
        0:       op = 5'b01100;
        1:       op = 5'b00100;
        2:       op = 5'b00101;
        3:       op = 5'b01101;
        4:       op = 5'b11000;
        5:       op = 5'b11011;
        6:       op = 5'b11001;
        7:       op = 5'b00000;
        8:       op = 5'b01000;
        9:       op = 5'b01011;
        10:      op = 5'b11100;
        11:      op = 5'b00011;
        default: op = 5'b11111;
    endcase
    word      = $urandom;
    word[6:0] = {op, 2'b11};
    // Keep markers out of random traffic
    if (word == `START_MARKER || word == `END_MARKER)
        word[20] = ~word[20];
    return word;
endfunction

//////////////////////////////
// AXI4-Lite master side
//////////////////////////////
task automatic axil_write(input logic [7:0] addr, input logic [31:0] data, input int stall);
    stats_bus_pkg::axil_resp_t resp;
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    bready  <= 1'b0;
    @(posedge clk);
    while (!awready)
        @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge clk);
    if (!bvalid)
        report_error("bvalid not raised the cycle after the write was accepted");
    resp = bresp;
    repeat (stall) begin
        @(posedge clk);
        if (!bvalid)
            report_error("bvalid dropped while bready was held low");
        if (bresp !== resp)
            report_mismatch("bresp (held)", 32'(resp), 32'(bresp));
    end
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
endtask

task automatic axil_read(input logic [7:0] addr, input int stall, output logic [31:0] data);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b0;
    @(posedge clk);
    while (!arready)
        @(posedge clk);
    arvalid <= 1'b0;
    @(posedge clk);
    if (!rvalid)
        report_error("rvalid not raised the cycle after the read was accepted");
    data = rdata;
    repeat (stall) begin
        @(posedge clk);
        if (!rvalid)
            report_error("rvalid dropped while rready was held low");
        if (rdata !== data)
            report_mismatch("rdata (held)", data, rdata);
    end
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
endtask

`endif

//--- verif/retire_stats_tb.sv
`timescale 1ns/1ps
`include "retire_stats_config.svh"

module retire_stats_tb;

    localparam int PORTS         = `RETIRE_PORTS;
    localparam int PRE_CYCLES    = 40;
    localparam int WIN_CYCLES    = 200;
    localparam int SHORT_CYCLES  = 12;
    localparam int UART_WRITES   = 8;
    localparam int BUS_OPS       = 100;
    localparam int BUS_OP_CYCLES = 12;
    // Traffic, idle gaps and reset with a 4x margin on top
    localparam int STIM_CYCLES   = 4 + PRE_CYCLES + WIN_CYCLES + 5 * SHORT_CYCLES + 60;
    localparam int MAX_CYCLES    = 4 * (STIM_CYCLES + BUS_OPS * BUS_OP_CYCLES);

    logic                      clk;
    logic                      arst_n;
    logic [PORTS-1:0]          retire_valid;
    logic [31:0]               retire_instr [PORTS];
    logic [7:0]                awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [31:0]               wdata;
    logic [3:0]                wstrb;
    logic                      wvalid;
    logic                      wready;
    stats_bus_pkg::axil_resp_t bresp;
    logic                      bvalid;
    logic                      bready;
    logic [7:0]                araddr;
    logic                      arvalid;
    logic                      arready;
    logic [31:0]               rdata;
    stats_bus_pkg::axil_resp_t rresp;
    logic                      rvalid;
    logic                      rready;
    logic                      uart_valid;
    logic [7:0]                uart_byte;
    logic                      collect_active;

    // Expected state
    logic [`COUNTER_W-1:0]     exp_mix [rv_decode_pkg::MIX_COUNT];
    logic [`COUNTER_W-1:0]     exp_retired;
    logic [`COUNTER_W-1:0]     exp_cycles;
    logic                      exp_active;
    logic                      exp_done;
    logic [31:0]               exp_rdata;
    stats_bus_pkg::axil_resp_t exp_rresp;
    stats_bus_pkg::axil_resp_t exp_bresp;
    string                     exp_rname;
    logic [7:0]                uart_exp_q [$];
    logic [7:0]                uart_next;
    int                        mismatch_count;
    int                        error_count;
    int                        run_cycles;

    retire_stats DUT (.*);

    `include "retire_stats_tb_util.svh"

    always #50 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        mismatch_count++;
        $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("Error at %0t: %s", $time, what);
    endtask

    function automatic logic is_mapped(input logic [7:0] addr);
        if (addr == `REG_STATUS || addr == `REG_CONTROL || addr == `REG_RETIRED ||
            addr == `REG_CYCLES || addr == `REG_UART)
            return 1'b1;
        return addr >= `REG_MIX_BASE && addr[1:0] == 2'b00 &&
               addr < `REG_MIX_BASE + 8'(4 * rv_decode_pkg::MIX_COUNT);
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////
    task automatic clear_model();
        exp_mix     = '{default: '0};
        exp_retired = '0;
        exp_cycles  = '0;
        exp_done    = 1'b0;
    endtask

    // Window rules for one sampled retire cycle
    task automatic apply_retire();
        rv_decode_pkg::mix_vec_t mix;
        logic                    start_hit;
        logic                    end_hit;
        start_hit = 1'b0;
        end_hit   = 1'b0;
        for (int p = 0; p < PORTS; p++) begin
            if (retire_valid[p] && retire_instr[p] == `START_MARKER)
                start_hit = 1'b1;
            if (retire_valid[p] && retire_instr[p] == `END_MARKER)
                end_hit = 1'b1;
        end
        if (!exp_active) begin
            if (start_hit) begin
                exp_active = 1'b1;
                exp_done   = 1'b0;
            end
        end else begin
            exp_cycles++;
            for (int p = 0; p < PORTS; p++) begin
                if (retire_valid[p] && retire_instr[p] != `START_MARKER &&
                    retire_instr[p] != `END_MARKER) begin
                    exp_retired++;
                    mix = ref_classify(retire_instr[p]);
                    for (int c = 0; c < rv_decode_pkg::MIX_COUNT; c++)
                        exp_mix[c] += `COUNTER_W'(mix[c]);
                end
            end
            if (end_hit) begin
                exp_active = 1'b0;
                exp_done   = 1'b1;
            end
        end
    endtask

    task automatic expect_read(input logic [7:0] addr);
        exp_rdata = '0;
        exp_rresp = is_mapped(addr) ? stats_bus_pkg::RESP_OKAY : stats_bus_pkg::RESP_SLVERR;
        exp_rname = $sformatf("rdata @%h", addr);
        if (addr == `REG_STATUS) begin
            exp_rdata[stats_bus_pkg::STATUS_ACTIVE] = exp_active;
            exp_rdata[stats_bus_pkg::STATUS_DONE]   = exp_done;
            exp_rname = "status";
        end else if (addr == `REG_RETIRED) begin
            exp_rdata = exp_retired;
            exp_rname = "retired";
        end else if (addr == `REG_CYCLES) begin
            exp_rdata = exp_cycles;
            exp_rname = "cycles";
        end else if (is_mapped(addr) && addr >= `REG_MIX_BASE && addr < `REG_UART) begin
            exp_rdata = exp_mix[(addr - `REG_MIX_BASE) >> 2];
            exp_rname = $sformatf("mix[%0d]", (addr - `REG_MIX_BASE) >> 2);
        end
    endtask

    //////////////////////////////
    // Checker
    //////////////////////////////
    always @(posedge clk) begin
        if (!arst_n) begin
            clear_model();
            exp_active = 1'b0;
        end else begin
            apply_retire();
            if (awready !== wready)
                report_error("awready and wready out of step");
            // Clear lands after this cycle's update and wins over it
            if (awvalid && wvalid && awready && wready) begin
                exp_bresp = is_mapped(awaddr) ? stats_bus_pkg::RESP_OKAY
                                              : stats_bus_pkg::RESP_SLVERR;
                if (awaddr == `REG_CONTROL && wstrb[0] && wdata[0])
                    clear_model();
                if (awaddr == `REG_UART && wstrb[0])
                    uart_exp_q.push_back(wdata[7:0]);
            end
            if (bvalid && bready) begin
                if (bresp !== exp_bresp)
                    report_mismatch("bresp", 32'(exp_bresp), 32'(bresp));
            end
            if (arvalid && arready)
                expect_read(araddr);
            if (rvalid && rready) begin
                if (rdata !== exp_rdata)
                    report_mismatch(exp_rname, exp_rdata, rdata);
                if (rresp !== exp_rresp)
                    report_mismatch("rresp", 32'(exp_rresp), 32'(rresp));
            end
            if (uart_valid) begin
                if (uart_exp_q.size() == 0) begin
                    report_error("uart_valid pulsed without a pending UART write");
                end else begin
                    uart_next = uart_exp_q.pop_front();
                    if (uart_byte !== uart_next)
                        report_mismatch("uart_byte", 32'(uart_next), 32'(uart_byte));
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        run_cycles++;
        if (run_cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not complete", run_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic drive_retire(input logic [PORTS-1:0] valid, input logic [31:0] instr0,
                                input logic [31:0] instr1);
        retire_valid    <= valid;
        retire_instr[0] <= instr0;
        retire_instr[1] <= instr1;
        @(posedge clk);
    endtask

    task automatic idle(input int cycles);
        retire_valid <= '0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic random_traffic(input int cycles);
        for (int i = 0; i < cycles; i++)
            drive_retire(PORTS'($urandom), rand_instr(), rand_instr());
    endtask

    // Reads every statistic register for the checker to compare
    task automatic read_all_stats();
        logic [31:0] data;
        axil_read(`REG_STATUS, 0, data);
        axil_read(`REG_RETIRED, 0, data);
        axil_read(`REG_CYCLES, 0, data);
        for (int c = 0; c < rv_decode_pkg::MIX_COUNT; c++)
            axil_read(`REG_MIX_BASE + 8'(4 * c), 0, data);
        if (collect_active !== exp_active)
            report_mismatch("collect_active", 32'(exp_active), 32'(collect_active));
    endtask

    task automatic run_window(input int cycles);
        drive_retire(PORTS'($urandom) | 1'b1, `START_MARKER, rand_instr());
        random_traffic(cycles);
        drive_retire(PORTS'($urandom) | 1'b1, `END_MARKER, rand_instr());
        idle(3);
    endtask

    initial begin
        logic [31:0] data;
        void'($urandom(32'h8468c5d6));
        clk            = 1'b0;
        arst_n         = 1'b0;
        retire_valid   = '0;
        retire_instr   = '{default: '0};
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = '0;
        wvalid         = 1'b0;
        bready         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        mismatch_count = 0;
        error_count    = 0;
        run_cycles     = 0;
        clear_model();
        exp_active = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        idle(2);

        // Reset values
        if (collect_active !== 1'b0)
            report_error("collect_active high after reset");
        read_all_stats();

        // Traffic outside a window, then a long random window
        random_traffic(PRE_CYCLES);
        idle(3);
        read_all_stats();
        run_window(WIN_CYCLES);
        // Done set and active clear once the end marker retires
        axil_read(`REG_STATUS, 0, data);
        if (data !== 32'h0000_0002)
            report_mismatch("status after end marker", 32'h0000_0002, data);
        read_all_stats();

        // Markers sharing cycles with other instructions, both port orders
        drive_retire(2'b11, `START_MARKER, 32'h002081B3);
        random_traffic(SHORT_CYCLES);
        drive_retire(2'b11, 32'h0000A103, `END_MARKER);
        idle(3);
        read_all_stats();
        drive_retire(2'b11, 32'h02208133, `START_MARKER);
        random_traffic(SHORT_CYCLES);
        drive_retire(2'b11, `END_MARKER, 32'h0220C133);
        idle(3);
        read_all_stats();

        // Counter clear, then a fresh window
        axil_write(`REG_CONTROL, 32'h1, 0);
        idle(2);
        read_all_stats();
        run_window(SHORT_CYCLES);
        read_all_stats();

        // Console bytes and a write to a read-only counter
        for (int i = 0; i < UART_WRITES; i++)
            axil_write(`REG_UART, $urandom, 0);
        axil_write(`REG_CYCLES, 32'hFFFF_FFFF, 0);
        idle(2);
        read_all_stats();

        // Unmapped offsets, zero-read registers and held ready signals
        axil_read(8'h2C, 0, data);
        axil_read(8'h13, 0, data);
        axil_read(`REG_UART, 0, data);
        axil_read(`REG_CONTROL, 0, data);
        axil_read(`REG_RETIRED, 5, data);
        axil_read(8'h80, 4, data);
        axil_write(8'h30, 32'h5A, 5);
        axil_write(`REG_STATUS, 32'h0, 3);
        idle(2);
        read_all_stats();

        if (uart_exp_q.size() != 0)
            report_error("UART write accepted without a uart_valid pulse");
        $display("Run complete: %0d mismatches, %0d other errors",
                 mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- retire_stats.f
+incdir+verilog
+incdir+verif
verilog/rv_decode_pkg.sv
verilog/stats_bus_pkg.sv
verilog/retire_classifier.sv
verilog/collection_counters.sv
verilog/stats_axil_slave.sv
verilog/retire_stats.sv
verif/retire_stats_tb.sv

//--- Makefile
# Verilator build and run of the retire statistics testbench

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = retire_stats_tb
FILELIST = retire_stats.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
